//--- test/fetch_patterns.txt
// word 0: seed word, xor'ed into each memory word's byte address
// then one record per test: entries, refill latency, dequeue spacing, hold (1 = withhold deq)
a5c30f17
// short refill, dequeue as fast as possible
00000028 00000001 00000000 00000000
// long refill, same stream expected
00000028 0000000c 00000000 00000000
// slow consumer
00000018 00000003 00000002 00000000
// queue fills before the first dequeue
00000020 00000005 00000000 00000001
// very long refill with back-pressure
00000014 00000014 00000005 00000001
// immediate memory answer
00000011 00000000 00000001 00000000
// end of list
00000000 00000000 00000000 00000000

//--- vlog.f
+incdir+design
design/fetch_pkg.sv
design/sync_fifo.sv
design/if1_stage.sv
design/icache.sv
design/fetch_frontend.sv
design/fetch_top.sv
test/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the fetch frontend testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module fetch_tb -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi

exit 0

//--- test/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

    import fetch_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         deq;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;
    fetch_entry_t entry;
    logic         empty;

    logic [31:0] pat [0:63];
    logic [31:0] word_seed;
    int          seed;
    int          latency;
    int          req_count;
    int          mem_rises;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          checks;
    int          tests;
    string       test_name;

    fetch_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .mem_resp (mem_resp),
        .deq      (deq),
        .entry    (entry),
        .empty    (empty)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("mismatch %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // every word is its own byte address mixed with the seed word.
    function automatic logic [`ICACHE_LINE_WORDS*32-1:0] make_line(input logic [31:0] addr);
        logic [`ICACHE_LINE_WORDS*32-1:0] line;
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            line[w*32 +: 32] = (addr + 32'(w * 4)) ^ word_seed;
        end
        return line;
    endfunction

    // enough cycles to fill the queue and park one more word in if1.
    function automatic int hold_cycles(input int lat);
        return (`FETCH_QUEUE_DEPTH + 2) * 4 + 3 * (lat + 4);
    endfunction

    // ==============================
    // memory model
    // ==============================

    initial begin : memory_model
        logic pending;
        logic read_prev;
        int   wait_left;
        mem_resp  = '0;
        pending   = 1'b0;
        read_prev = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                mem_resp  = '0;
                pending   = 1'b0;
                read_prev = 1'b0;
                req_count = 0;
                mem_rises = 0;
            end else begin
                if (mem_req.read && !read_prev) begin
                    mem_rises = mem_rises + 1;
                end
                read_prev      = mem_req.read;
                mem_resp.valid = 1'b0;
                if (mem_req.read && !pending) begin
                    // lines are requested strictly in order, each one once.
                    check_value({test_name, " mem addr"},
                                (`FETCH_RESET_VECTOR & ~32'h1f) + 32'(req_count * 32),
                                mem_req.addr);
                    check_value({test_name, " mem align"}, 32'd0, {27'b0, mem_req.addr[4:0]});
                    req_count = req_count + 1;
                    pending   = 1'b1;
                    wait_left = latency;
                end
                if (pending) begin
                    if (wait_left == 0) begin
                        mem_resp.valid = 1'b1;
                        mem_resp.line  = make_line(mem_req.addr);
                        pending        = 1'b0;
                    end else begin
                        wait_left = wait_left - 1;
                    end
                end
            end
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        deq   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_test(input int num, input int entries, input int lat,
                            input int spacing, input int hold);
        logic [31:0] exp_pc;
        logic [31:0] r;
        int          gap;
        int          errs_before;
        errs_before = errors;
        test_name   = $sformatf("t%0d_lat%0d", num, lat);
        latency     = lat;
        apply_reset();
        check_value({test_name, " empty after reset"}, 32'd1, {31'b0, empty});
        check_value({test_name, " mem read after reset"}, 32'd0, {31'b0, mem_req.read});
        if (hold != 0) begin
            repeat (hold_cycles(lat)) @(negedge clk);
        end
        exp_pc = `FETCH_RESET_VECTOR;
        for (int i = 0; i < entries; i++) begin
            r   = $random(seed);
            gap = spacing + int'(r[0]);
            repeat (gap) begin
                deq = 1'b0;
                @(negedge clk);
            end
            if (hold != 0 && i < `FETCH_QUEUE_DEPTH) begin
                check_value({test_name, " queue filled"}, 32'd0, {31'b0, empty});
            end
            while (empty) begin
                deq = 1'b0;
                @(negedge clk);
            end
            check_value({test_name, " pc"}, exp_pc, entry.pc);
            check_value({test_name, " inst"}, exp_pc ^ word_seed, entry.inst);
            exp_pc = exp_pc + 32'd4;
            deq    = 1'b1;
            @(negedge clk);
        end
        deq = 1'b0;
        check_value({test_name, " mem read rises"}, 32'(req_count), 32'(mem_rises));
        tests = tests + 1;
        $display("%0s: %0d entries, %0d line fills, %0s", test_name, entries, req_count,
                 (errors == errs_before) ? "pass" : "fail");
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin : main
        int idx;
        int limit;
        rst_n       = 1'b0;
        deq         = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        cycles      = 0;
        cycle_limit = 0;
        seed        = 32'h58c2_3c09;
        test_name   = "reset";
        for (int i = 0; i < 64; i++) begin
            pat[i] = 32'd0;
        end
        $readmemh("test/fetch_patterns.txt", pat);
        word_seed = pat[0];

        // records: entries, latency, spacing, hold; zero entries ends the list.
        limit = 0;
        idx   = 1;
        while (idx < 61 && pat[idx] != 0) begin
            limit = limit + int'(pat[idx]) * (int'(pat[idx+1]) + int'(pat[idx+2]) + 1 + 4);
            limit = limit + hold_cycles(int'(pat[idx+1])) + int'(pat[idx+1]) + 16;
            idx   = idx + 4;
        end
        cycle_limit = limit + 8;

        idx = 1;
        while (idx < 61 && pat[idx] != 0) begin
            run_test((idx + 3) / 4, int'(pat[idx]), int'(pat[idx+1]),
                     int'(pat[idx+2]), int'(pat[idx+3]));
            idx = idx + 4;
        end
        if (tests == 0) begin
            $display("no test records were read from the pattern file");
            errors = errors + 1;
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    output fetch_pkg::mem_req_t       mem_req,
    input  wire fetch_pkg::mem_resp_t mem_resp,
    input  wire logic                 deq,
    output fetch_pkg::fetch_entry_t   entry,
    output logic                      empty
);

    import fetch_pkg::*;

    cache_req_t  cache_req;
    cache_resp_t cache_resp;

    fetch_frontend u_frontend (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_req  (cache_req),
        .cache_resp (cache_resp),
        .deq        (deq),
        .entry      (entry),
        .empty      (empty)
    );

    // the cache owns the memory port alone.
    icache u_icache (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_req  (cache_req),
        .cache_resp (cache_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

endmodule

`default_nettype wire

//--- design/fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_frontend (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    output fetch_pkg::cache_req_t       cache_req,
    input  wire fetch_pkg::cache_resp_t cache_resp,
    input  wire logic                   deq,
    output fetch_pkg::fetch_entry_t     entry,
    output logic                        empty
);

    import fetch_pkg::*;

    logic        rst_seen;
    logic        first_cycle;
    logic [31:0] pc_next;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        if1_valid;
    logic        icache_unresponsive;
    logic        queue_full;
    logic        stall;
    logic        enq;

    fetch_entry_t                      enq_entry;
    logic [$bits(fetch_entry_t)-1:0]   head_data;

    // ==============================
    // next pc
    // ==============================

    // low only on the first cycle out of reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_seen <= 1'b0;
        end else begin
            rst_seen <= 1'b1;
        end
    end

    assign first_cycle = !rst_seen;
    assign pc_next     = first_cycle ? `FETCH_RESET_VECTOR : pc + 32'd4;
    assign stall       = icache_unresponsive || queue_full;

    if1_stage u_if1 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc_next             (pc_next),
        .stall               (stall),
        .pc                  (pc),
        .inst                (inst),
        .valid               (if1_valid),
        .icache_unresponsive (icache_unresponsive),
        .cache_req           (cache_req),
        .cache_resp          (cache_resp)
    );

    // ==============================
    // instruction queue
    // ==============================

    assign enq = if1_valid && !queue_full;

    always_comb begin
        enq_entry.pc   = pc;
        enq_entry.inst = inst;
    end

    sync_fifo #(
        .DEPTH (`FETCH_QUEUE_DEPTH),
        .WIDTH ($bits(fetch_entry_t))
    ) u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .enq      (enq),
        .enq_data (enq_entry),
        .full     (queue_full),
        .deq      (deq),
        .deq_data (head_data),
        .empty    (empty)
    );

    assign entry = fetch_entry_t'(head_data);

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module icache (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire fetch_pkg::cache_req_t  cache_req,
    output fetch_pkg::cache_resp_t      cache_resp,
    output fetch_pkg::mem_req_t         mem_req,
    input  wire fetch_pkg::mem_resp_t   mem_resp
);

    import fetch_pkg::*;

    localparam int LINE_BITS = `ICACHE_LINE_WORDS * 32;
    localparam int OFF_BITS  = $clog2(`ICACHE_LINE_WORDS);
    localparam int IDX_BITS  = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS  = 32 - IDX_BITS - OFF_BITS - 2;

    icache_state_e state;

    logic [31:0] addr_q;
    logic [31:0] inst_q;

    logic [LINE_BITS-1:0]      data_mem [`ICACHE_LINES];
    logic [TAG_BITS-1:0]       tag_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  line_valid;

    logic [OFF_BITS-1:0] word_sel;
    logic [IDX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;
    logic                hit;

    // address split: tag | index | word | byte.
    assign word_sel = addr_q[OFF_BITS+1:2];
    assign index    = addr_q[IDX_BITS+OFF_BITS+1:OFF_BITS+2];
    assign tag      = addr_q[31:IDX_BITS+OFF_BITS+2];
    assign hit      = line_valid[index] && (tag_mem[index] == tag);

    // ==============================
    // miss handling FSM
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            line_valid <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cache_req.read) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    state <= hit ? respond : refill;
                end
                refill: begin
                    if (mem_resp.valid) begin
                        line_valid[index] <= 1'b1;
                        state             <= respond;
                    end
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // line storage and the word handed back.
    always_ff @(posedge clk) begin
        if (state == idle && cache_req.read) begin
            addr_q <= cache_req.addr;
        end
        if (state == lookup && hit) begin
            inst_q <= data_mem[index][word_sel*32 +: 32];
        end
        if (state == refill && mem_resp.valid) begin
            data_mem[index] <= mem_resp.line;
            tag_mem[index]  <= tag;
            inst_q          <= mem_resp.line[word_sel*32 +: 32];
        end
    end

    always_comb begin
        cache_resp.resp_valid = (state == respond);
        cache_resp.inst       = inst_q;
        mem_req.read          = (state == refill);
        mem_req.addr          = {addr_q[31:OFF_BITS+2], {(OFF_BITS + 2){1'b0}}};
    end

endmodule

`default_nettype wire

//--- design/if1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module if1_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [31:0]            pc_next,
    input  wire logic                   stall,
    output logic [31:0]                 pc,
    output logic [31:0]                 inst,
    output logic                        valid,
    output logic                        icache_unresponsive,
    output fetch_pkg::cache_req_t       cache_req,
    input  wire fetch_pkg::cache_resp_t cache_resp
);

    logic        read_q;
    logic        outstanding;
    logic        held_valid;
    logic [31:0] held_inst;

    // one read per pc, issued the cycle after pc loads.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            read_q      <= 1'b0;
            outstanding <= 1'b0;
            held_valid  <= 1'b0;
        end else begin
            read_q <= !stall;
            if (!stall) begin
                pc <= pc_next;
            end
            if (read_q) begin
                outstanding <= 1'b1;
            end else if (cache_resp.resp_valid) begin
                outstanding <= 1'b0;
            end
            // keep the word while the queue refuses it.
            held_valid <= valid && stall;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_resp.resp_valid) begin
            held_inst <= cache_resp.inst;
        end
    end

    assign valid = cache_resp.resp_valid || held_valid;
    assign inst  = held_valid ? held_inst : cache_resp.inst;

    // the read cycle itself counts as waiting.
    assign icache_unresponsive = read_q || (outstanding && !cache_resp.resp_valid);

    always_comb begin
        cache_req.read = read_q;
        cache_req.addr = pc;
    end

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 64
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             enq,
    input  wire logic [WIDTH-1:0] enq_data,
    output logic                  full,
    input  wire logic             deq,
    output logic [WIDTH-1:0]      deq_data,
    output logic                  empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_enq;
    logic                do_deq;

    // a full queue refuses enq even when deq frees a slot.
    assign do_enq = enq && !full;
    assign do_deq = deq && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    assign deq_data = mem[rd_ptr];
    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } cache_req_t;

    typedef struct packed {
        logic        resp_valid;
        logic [31:0] inst;
    } cache_resp_t;

    // read is a level, held until the line comes back.
    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                              valid;
        logic [`ICACHE_LINE_WORDS*32-1:0]  line;
    } mem_resp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        refill,
        respond
    } icache_state_e;

endpackage

`default_nettype wire

//--- design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address after reset.
`define FETCH_RESET_VECTOR 32'h1eceb000

// instruction queue entries.
`define FETCH_QUEUE_DEPTH 8

// direct-mapped cache geometry.
`define ICACHE_LINES 4

// one line is this many 32-bit words.
`define ICACHE_LINE_WORDS 8

`endif
